// File: list.f
rtl/dual_pkg.sv
rtl/issue_decode.sv
rtl/lane_execute.sv
rtl/writeback_stage.sv
rtl/reg_file.sv
rtl/csr_file.sv
rtl/dual_core_top.sv
verification/dual_core_checker.sv
verification/dual_core_sva.sv
verification/dual_core_tb.sv

// File: Makefile
TOP = dual_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

// File: verification/dual_core_tb.sv
`timescale 1ns/10ps

module dual_core_tb import dual_pkg::*; ();

  localparam int NUM_TESTS   = 20;
  localparam int CYCLE_LIMIT = 8 * NUM_TESTS + 50;

  // one expected commit
  typedef struct packed {
    logic [1:0]  lane;
    logic        we;
    logic [4:0]  dest;
    logic [31:0] data;
    logic        csr;
    logic [13:0] csr_num;
    logic [31:0] csr_data;
  } exp_t;

  logic       clk;
  logic       reset;
  logic       pair_valid;
  inst_pair_t pair;
  logic       pair_ready;
  logic       commit_ready;
  commit_t    commit1;
  commit_t    commit2;
  csr_wr_t    csr_wr;

  string      names [NUM_TESTS];
  inst_pair_t pairs [NUM_TESTS];
  exp_t       exp1 [NUM_TESTS];
  exp_t       exp2 [NUM_TESTS];
  int         n_tests;
  int         idx;
  int         cycles;
  integer     seed;

  dual_core_top DUT (
    .clk, .reset, .pair_valid, .pair, .pair_ready, .commit_ready,
    .commit1, .commit2, .csr_wr
  );

  dual_core_checker chk (
    .clk, .reset, .commit_ready, .commit1, .commit2, .csr_wr
  );

  function automatic inst_u r_inst(input op_e op, input logic [4:0] rd,
                                   input logic [4:0] rj, input logic [4:0] rk);
    inst_u w;
    w = '0;
    w.r_form.opcode = op;
    w.r_form.rd     = rd;
    w.r_form.rj     = rj;
    w.r_form.rk     = rk;
    return w;
  endfunction

  function automatic inst_u i_inst(input op_e op, input logic [4:0] rd,
                                   input logic [4:0] rj, input logic [13:0] field);
    inst_u w;
    w = '0;
    w.i_form.opcode = op;
    w.i_form.rd     = rd;
    w.i_form.rj     = rj;
    w.i_form.field  = field;
    return w;
  endfunction

  function automatic exp_t commit_exp(input int lane, input logic we, input logic [4:0] dest,
                                      input logic [31:0] data);
    exp_t e;
    e      = '0;
    e.lane = lane[1:0];
    e.we   = we;
    e.dest = dest;
    e.data = data;
    return e;
  endfunction

  // csrwr commit, with the csr write it must show
  function automatic exp_t csr_exp(input int lane, input logic [4:0] dest,
                                   input logic [31:0] data, input logic [13:0] num,
                                   input logic [31:0] wdata);
    exp_t e;
    e          = commit_exp(lane, 1'b1, dest, data);
    e.csr      = 1'b1;
    e.csr_num  = num;
    e.csr_data = wdata;
    return e;
  endfunction

  task automatic add_test(input string name, input inst_u i1, input inst_u i2,
                          input exp_t e1, input exp_t e2);
    names[n_tests] = name;
    pairs[n_tests] = '{inst1: i1, inst2: i2};
    exp1[n_tests]  = e1;
    exp2[n_tests]  = e2;
    n_tests++;
  endtask

  task automatic queue_expect(input string name, input exp_t e, input bit last);
    chk.add_expect(name, e.lane, e.we, e.dest, e.data, e.csr, e.csr_num, e.csr_data, last);
  endtask

  // values follow by hand from earlier tests; split pairs commit twice in lane 1
  task automatic load_tests();
    add_test("fill_r1_r2", i_inst(OP_ADDI, 1, 0, 14'd5), i_inst(OP_ADDI, 2, 0, 14'd12),
             commit_exp(1, 1, 1, 32'd5), commit_exp(2, 1, 2, 32'd12));
    add_test("fill_r3_neg", i_inst(OP_ADDI, 3, 0, 14'h0f0), i_inst(OP_ADDI, 4, 0, 14'hffd),
             commit_exp(1, 1, 3, 32'h0f0), commit_exp(2, 1, 4, 32'hfffffffd));
    add_test("add_sub", r_inst(OP_ADD, 5, 1, 2), r_inst(OP_SUB, 6, 2, 1),
             commit_exp(1, 1, 5, 32'd17), commit_exp(2, 1, 6, 32'd7));
    add_test("and_or", r_inst(OP_AND, 7, 3, 4), r_inst(OP_OR, 8, 1, 2),
             commit_exp(1, 1, 7, 32'h0f0), commit_exp(2, 1, 8, 32'd13));
    add_test("xor_fwd", r_inst(OP_XOR, 9, 5, 6), r_inst(OP_ADD, 10, 7, 8),
             commit_exp(1, 1, 9, 32'd22), commit_exp(2, 1, 10, 32'd253));
    add_test("write_r0", r_inst(OP_ADD, 0, 1, 2), i_inst(OP_ADDI, 11, 0, 14'hfff),
             commit_exp(1, 0, 0, 32'd17), commit_exp(2, 1, 11, 32'hffffffff));
    add_test("split_rj", i_inst(OP_ADDI, 12, 1, 14'd100), r_inst(OP_ADD, 13, 12, 2),
             commit_exp(1, 1, 12, 32'd105), commit_exp(1, 1, 13, 32'd117));
    add_test("same_dest", i_inst(OP_ADDI, 14, 0, 14'd7), i_inst(OP_ADDI, 14, 0, 14'd9),
             commit_exp(1, 0, 14, 32'd7), commit_exp(2, 1, 14, 32'd9));
    add_test("read_same_dest", r_inst(OP_ADD, 15, 14, 0), r_inst(OP_SUB, 16, 14, 1),
             commit_exp(1, 1, 15, 32'd9), commit_exp(2, 1, 16, 32'd4));
    add_test("csr_first", i_inst(OP_CSRWR, 17, 1, 14'd3), i_inst(OP_ADDI, 18, 0, 14'd1),
             csr_exp(1, 17, 32'd0, 14'd3, 32'd5), commit_exp(2, 1, 18, 32'd1));
    add_test("csr_second", i_inst(OP_CSRWR, 19, 2, 14'd3), r_inst(OP_XOR, 20, 1, 1),
             csr_exp(1, 19, 32'd5, 14'd3, 32'd12), commit_exp(2, 1, 20, 32'd0));
    add_test("csr_pair_split", i_inst(OP_CSRWR, 21, 3, 14'd5), i_inst(OP_CSRWR, 22, 4, 14'd3),
             csr_exp(1, 21, 32'd0, 14'd5, 32'h0f0), csr_exp(1, 22, 32'd12, 14'd3, 32'hfffffffd));
    add_test("csr_read_back", i_inst(OP_CSRWR, 23, 0, 14'd5), i_inst(OP_ADDI, 24, 0, 14'h7ff),
             csr_exp(1, 23, 32'h0f0, 14'd5, 32'd0), commit_exp(2, 1, 24, 32'd2047));
    add_test("csr_high_num", i_inst(OP_CSRWR, 25, 0, 14'h13), r_inst(OP_AND, 26, 24, 11),
             csr_exp(1, 25, 32'hfffffffd, 14'h13, 32'd0), commit_exp(2, 1, 26, 32'd2047));
    add_test("chain_ex", r_inst(OP_ADD, 27, 24, 24), r_inst(OP_SUB, 28, 11, 24),
             commit_exp(1, 1, 27, 32'd4094), commit_exp(2, 1, 28, 32'hfffff800));
    add_test("split_rk", r_inst(OP_XOR, 29, 1, 2), r_inst(OP_OR, 30, 0, 29),
             commit_exp(1, 1, 29, 32'd9), commit_exp(1, 1, 30, 32'd9));
    add_test("after_split", r_inst(OP_ADD, 31, 30, 29), r_inst(OP_SUB, 1, 27, 28),
             commit_exp(1, 1, 31, 32'd18), commit_exp(2, 1, 1, 32'd6142));
    add_test("new_r1", i_inst(OP_ADDI, 2, 1, 14'hffe), r_inst(OP_ADD, 3, 1, 1),
             commit_exp(1, 1, 2, 32'd6140), commit_exp(2, 1, 3, 32'd12284));
    add_test("imm_limits", i_inst(OP_ADDI, 4, 0, 14'h800), i_inst(OP_ADDI, 5, 0, 14'h7ff),
             commit_exp(1, 1, 4, 32'hfffff800), commit_exp(2, 1, 5, 32'h7ff));
    add_test("final_mix", r_inst(OP_SUB, 6, 5, 4), r_inst(OP_XOR, 7, 3, 2),
             commit_exp(1, 1, 6, 32'hfff), commit_exp(2, 1, 7, 32'h3800));
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // run limit in clock cycles
  initial begin
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
        $display("timeout: commits still missing after %0d cycles", cycles);
        $display("*** TEST FAILED ***");
        $finish;
      end
    end
  end

  initial begin
    seed         = 32'he139;
    reset        = 1'b1;
    pair_valid   = 1'b0;
    pair         = '0;
    commit_ready = 1'b0;
    n_tests      = 0;
    load_tests();
    for (int t = 0; t < n_tests; t++) begin
      queue_expect(names[t], exp1[t], 1'b0);
      queue_expect(names[t], exp2[t], 1'b1);
    end
    repeat (4) @(posedge clk);
    #10;
    reset = 1'b0;
    idx   = 0;
    // hold each pair until it is taken
    while (idx < n_tests) begin
      pair_valid   = 1'b1;
      pair         = pairs[idx];
      commit_ready = ($random(seed) & 3) != 0;
      #1;
      if (pair_ready) idx++;
      @(posedge clk);
      #10;
    end
    pair_valid = 1'b0;
    pair       = '0;
    while (chk.rd_ptr < chk.wr_ptr) begin
      commit_ready = ($random(seed) & 3) != 0;
      @(posedge clk);
      #10;
    end
    // extra cycles catch repeated commits
    commit_ready = 1'b1;
    repeat (3) @(posedge clk);
    $display("tests passed %0d, failed %0d, errors %0d", chk.tests_passed,
             chk.tests_failed, chk.errors);
    if (chk.errors == 0 && chk.tests_failed == 0 && chk.tests_passed == n_tests) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: verification/dual_core_sva.sv
`timescale 1ns/10ps

module dual_core_sva import dual_pkg::*; (
  input logic     clk,
  input logic     reset,
  input logic     commit_ready,
  input wb_lane_t wb1,
  input wb_lane_t wb2,
  input rf_wr_t   rf_wr1,
  input rf_wr_t   rf_wr2,
  input csr_wr_t  csr_wr
);

  // a stalled commit is presented again unchanged
  assert property (@(posedge clk) disable iff (reset)
    !commit_ready && (wb1.valid || wb2.valid) |=> $stable(wb1) && $stable(wb2))
    else $error("write-back lanes changed while the commit sink stalls");

  // one csr write per commit
  assert property (@(posedge clk) disable iff (reset)
    csr_wr.we |-> !(wb1.valid && wb1.csr_we && wb2.valid && wb2.csr_we))
    else $error("two csr writes in one commit");

  // r0 never reaches a write port
  assert property (@(posedge clk) disable iff (reset)
    (!rf_wr1.we || rf_wr1.addr != 5'd0) && (!rf_wr2.we || rf_wr2.addr != 5'd0))
    else $error("register zero written by a write port");

endmodule

// write-back has no clock, so the top scope supplies it
bind dual_core_top dual_core_sva wb_sva (
  .clk, .reset, .commit_ready, .wb1, .wb2, .rf_wr1, .rf_wr2, .csr_wr
);

// File: verification/dual_core_checker.sv
`timescale 1ns/10ps

module dual_core_checker import dual_pkg::*; (
  input logic    clk,
  input logic    reset,
  input logic    commit_ready,
  input commit_t commit1,
  input commit_t commit2,
  input csr_wr_t csr_wr
);

  localparam int MAX_EXP = 64;

  string       exp_name [MAX_EXP];
  int          exp_lane [MAX_EXP];
  logic        exp_we [MAX_EXP];
  logic [4:0]  exp_dest [MAX_EXP];
  logic [31:0] exp_data [MAX_EXP];
  logic        exp_csr [MAX_EXP];
  logic [13:0] exp_csr_num [MAX_EXP];
  logic [31:0] exp_csr_data [MAX_EXP];
  bit          exp_last [MAX_EXP];

  int          wr_ptr = 0;
  int          rd_ptr = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          errors = 0;
  bit          test_bad = 0;
  bit          test_done = 0;
  string       done_name;
  logic        csr_expected;
  logic [13:0] csr_num_expected;
  logic [31:0] csr_data_expected;
  logic [31:0] pc_expected;
  string       cycle_name;

  task automatic add_expect(input string name, input int lane, input logic we,
                            input logic [4:0] dest, input logic [31:0] data,
                            input logic csr, input logic [13:0] csr_num,
                            input logic [31:0] csr_data, input bit last);
    exp_name[wr_ptr]     = name;
    exp_lane[wr_ptr]     = lane;
    exp_we[wr_ptr]       = we;
    exp_dest[wr_ptr]     = dest;
    exp_data[wr_ptr]     = data;
    exp_csr[wr_ptr]      = csr;
    exp_csr_num[wr_ptr]  = csr_num;
    exp_csr_data[wr_ptr] = csr_data;
    exp_last[wr_ptr]     = last;
    wr_ptr++;
  endtask

  task automatic check_one(input int lane, input commit_t c);
    if (rd_ptr >= wr_ptr) begin
      $display("unexpected extra commit on lane %0d for register %0d", lane, c.dest);
      errors++;
    end else begin
      cycle_name  = exp_name[rd_ptr];
      // one instruction per commit, pc starts at zero
      pc_expected = rd_ptr * 4;
      if (lane != exp_lane[rd_ptr] || c.we !== exp_we[rd_ptr] ||
          c.dest !== exp_dest[rd_ptr] || c.data !== exp_data[rd_ptr] ||
          c.pc !== pc_expected) begin
        $write("ERR %s: expected lane %0d we %0b dest %0d data %h pc %h,", exp_name[rd_ptr],
               exp_lane[rd_ptr], exp_we[rd_ptr], exp_dest[rd_ptr], exp_data[rd_ptr],
               pc_expected);
        $display(" actual lane %0d we %0b dest %0d data %h pc %h", lane, c.we, c.dest,
                 c.data, c.pc);
        errors++;
        test_bad = 1'b1;
      end
      if (exp_csr[rd_ptr]) begin
        csr_expected      = 1'b1;
        csr_num_expected  = exp_csr_num[rd_ptr];
        csr_data_expected = exp_csr_data[rd_ptr];
      end
      if (exp_last[rd_ptr]) begin
        test_done = 1'b1;
        done_name = exp_name[rd_ptr];
      end
      rd_ptr++;
    end
  endtask

  // outputs are sampled before the edge updates the stage registers
  always @(posedge clk) begin
    if (!reset && commit_ready) begin
      csr_expected      = 1'b0;
      csr_num_expected  = '0;
      csr_data_expected = '0;
      test_done         = 1'b0;
      cycle_name        = "none";
      if (commit1.valid === 1'b1) check_one(1, commit1);
      if (commit2.valid === 1'b1) check_one(2, commit2);
      if (csr_wr.we !== csr_expected ||
          (csr_expected && (csr_wr.num !== csr_num_expected ||
                            csr_wr.data !== csr_data_expected))) begin
        $display("ERR %s csr_wr: expected we %0b num %h data %h, actual we %0b num %h data %h",
                 cycle_name, csr_expected, csr_num_expected, csr_data_expected,
                 csr_wr.we, csr_wr.num, csr_wr.data);
        errors++;
        test_bad = 1'b1;
      end
      if (test_done) begin
        $display("%s %s", done_name, test_bad ? "fail" : "ok");
        if (test_bad) tests_failed++;
        else tests_passed++;
        test_bad = 1'b0;
      end
    end
  end

endmodule

// File: rtl/dual_core_top.sv
`timescale 1ns/10ps

module dual_core_top import dual_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       pair_valid,
  input  inst_pair_t pair,
  output logic       pair_ready,
  input  logic       commit_ready,
  output commit_t    commit1,
  output commit_t    commit2,
  output csr_wr_t    csr_wr
);

  logic             wb_ready;
  logic [3:0][4:0]  rf_raddr;
  logic [3:0][31:0] rf_rdata;
  dec_lane_t        dec1;
  dec_lane_t        dec2;
  fwd_t             ex_fwd1;
  fwd_t             ex_fwd2;
  fwd_t             wb_fwd1;
  fwd_t             wb_fwd2;
  wb_lane_t         wb1;
  wb_lane_t         wb2;
  rf_wr_t           rf_wr1;
  rf_wr_t           rf_wr2;
  logic [3:0]       csr_raddr1;
  logic [3:0]       csr_raddr2;
  logic [31:0]      csr_rdata1;
  logic [31:0]      csr_rdata2;

  issue_decode u_decode (
    .clk, .reset, .pair_valid, .pair, .pair_ready, .wb_ready,
    .rf_raddr, .rf_rdata, .ex_fwd1, .ex_fwd2, .wb_fwd1, .wb_fwd2, .dec1, .dec2
  );

  // lane 1 is the older instruction
  lane_execute lane1_ex (
    .clk, .reset, .wb_ready, .dec(dec1), .csr_rdata(csr_rdata1),
    .csr_raddr(csr_raddr1), .csr_wr, .ex_fwd(ex_fwd1), .wb(wb1)
  );

  lane_execute lane2_ex (
    .clk, .reset, .wb_ready, .dec(dec2), .csr_rdata(csr_rdata2),
    .csr_raddr(csr_raddr2), .csr_wr, .ex_fwd(ex_fwd2), .wb(wb2)
  );

  writeback_stage u_wb (
    .wb_ready, .commit_ready, .wb1, .wb2, .rf_wr1, .rf_wr2, .csr_wr,
    .wb_fwd1, .wb_fwd2, .commit1, .commit2
  );

  reg_file u_rf (.clk, .rf_raddr, .rf_rdata, .rf_wr1, .rf_wr2);

  csr_file u_csr (
    .clk, .reset, .csr_raddr1, .csr_raddr2, .csr_rdata1, .csr_rdata2, .csr_wr
  );

endmodule

// File: rtl/csr_file.sv
`timescale 1ns/10ps

module csr_file import dual_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic [3:0]  csr_raddr1,
  input  logic [3:0]  csr_raddr2,
  output logic [31:0] csr_rdata1,
  output logic [31:0] csr_rdata2,
  input  csr_wr_t     csr_wr
);

  logic [31:0] csrs [CSR_COUNT];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < CSR_COUNT; i++) begin
        csrs[i] <= 32'd0;
      end
    end else if (csr_wr.we) begin
      // upper number bits are ignored
      csrs[csr_wr.num[3:0]] <= csr_wr.data;
    end
  end

  assign csr_rdata1 = csrs[csr_raddr1];
  assign csr_rdata2 = csrs[csr_raddr2];

endmodule

// File: rtl/reg_file.sv
`timescale 1ns/10ps

module reg_file import dual_pkg::*; (
  input  logic             clk,
  input  logic [3:0][4:0]  rf_raddr,
  output logic [3:0][31:0] rf_rdata,
  input  rf_wr_t           rf_wr1,
  input  rf_wr_t           rf_wr2
);

  logic [31:0] regs [32];

  // lane 2 last, though write-back never sends both to one address
  always_ff @(posedge clk) begin
    if (rf_wr1.we && rf_wr1.addr != 5'd0) begin
      regs[rf_wr1.addr] <= rf_wr1.data;
    end
    if (rf_wr2.we && rf_wr2.addr != 5'd0) begin
      regs[rf_wr2.addr] <= rf_wr2.data;
    end
  end

  // r0 is hardwired
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      rf_rdata[i] = (rf_raddr[i] == 5'd0) ? 32'd0 : regs[rf_raddr[i]];
    end
  end

endmodule

// File: rtl/writeback_stage.sv
`timescale 1ns/10ps

module writeback_stage import dual_pkg::*; (
  output logic     wb_ready,
  input  logic     commit_ready,
  input  wb_lane_t wb1,
  input  wb_lane_t wb2,
  output rf_wr_t   rf_wr1,
  output rf_wr_t   rf_wr2,
  output csr_wr_t  csr_wr,
  output fwd_t     wb_fwd1,
  output fwd_t     wb_fwd2,
  output commit_t  commit1,
  output commit_t  commit2
);

  logic lane_we1;
  logic lane_we2;

  assign wb_ready = commit_ready;

  // lane 2 is younger, so it wins a shared destination
  assign lane_we2 = wb2.valid && wb2.gr_we;
  assign lane_we1 = wb1.valid && wb1.gr_we && !(lane_we2 && wb2.dest == wb1.dest);

  assign rf_wr1 = '{we: lane_we1 && commit_ready, addr: wb1.dest, data: wb1.result};
  assign rf_wr2 = '{we: lane_we2 && commit_ready, addr: wb2.dest, data: wb2.result};

  assign wb_fwd1 = '{valid: lane_we1, dest: wb1.dest, value: wb1.result};
  assign wb_fwd2 = '{valid: lane_we2, dest: wb2.dest, value: wb2.result};

  // decode never pairs two csrwr
  always_comb begin
    csr_wr = '0;
    if (wb1.valid && wb1.csr_we) begin
      csr_wr.we   = commit_ready;
      csr_wr.num  = wb1.csr_num;
      csr_wr.data = wb1.csr_wdata;
    end else if (wb2.valid && wb2.csr_we) begin
      csr_wr.we   = commit_ready;
      csr_wr.num  = wb2.csr_num;
      csr_wr.data = wb2.csr_wdata;
    end
  end

  assign commit1 = '{valid: wb1.valid, we: rf_wr1.we, dest: wb1.dest,
                     data: wb1.result, pc: wb1.pc};
  assign commit2 = '{valid: wb2.valid, we: rf_wr2.we, dest: wb2.dest,
                     data: wb2.result, pc: wb2.pc};

endmodule

// File: rtl/lane_execute.sv
`timescale 1ns/10ps

module lane_execute import dual_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        wb_ready,
  input  dec_lane_t   dec,
  input  logic [31:0] csr_rdata,
  output logic [3:0]  csr_raddr,
  input  csr_wr_t     csr_wr,
  output fwd_t        ex_fwd,
  output wb_lane_t    wb
);

  logic [31:0] csr_old;
  logic [31:0] result;

  assign csr_raddr = dec.csr_num[3:0];

  // a csr write at the commit edge is not in the file yet
  assign csr_old = (csr_wr.we && csr_wr.num[3:0] == dec.csr_num[3:0]) ? csr_wr.data : csr_rdata;

  always_comb begin
    case (dec.op)
      OP_ADD, OP_ADDI: result = dec.src1 + dec.src2;
      OP_SUB:          result = dec.src1 - dec.src2;
      OP_AND:          result = dec.src1 & dec.src2;
      OP_OR:           result = dec.src1 | dec.src2;
      OP_XOR:          result = dec.src1 ^ dec.src2;
      // old csr value goes back to rd
      OP_CSRWR:        result = csr_old;
      default:         result = 32'd0;
    endcase
  end

  assign ex_fwd.valid = dec.valid && dec.gr_we;
  assign ex_fwd.dest  = dec.dest;
  assign ex_fwd.value = result;

  always_ff @(posedge clk) begin
    if (reset) begin
      wb.valid <= 1'b0;
    end else if (wb_ready) begin
      wb.valid     <= dec.valid;
      wb.gr_we     <= dec.gr_we;
      wb.dest      <= dec.dest;
      wb.result    <= result;
      wb.csr_we    <= dec.csr_we;
      wb.csr_num   <= dec.csr_num;
      // rj value is the new csr contents
      wb.csr_wdata <= dec.src1;
      wb.pc        <= dec.pc;
    end
  end

endmodule

// File: rtl/issue_decode.sv
`timescale 1ns/10ps

module issue_decode import dual_pkg::*; (
  input  logic             clk,
  input  logic             reset,
  input  logic             pair_valid,
  input  inst_pair_t       pair,
  output logic             pair_ready,
  input  logic             wb_ready,
  output logic [3:0][4:0]  rf_raddr,
  input  logic [3:0][31:0] rf_rdata,
  input  fwd_t             ex_fwd1,
  input  fwd_t             ex_fwd2,
  input  fwd_t             wb_fwd1,
  input  fwd_t             wb_fwd2,
  output dec_lane_t        dec1,
  output dec_lane_t        dec2
);

  logic        out_of_reset;
  logic        held_valid;
  inst_u       held_inst;
  logic [31:0] pc_q;

  inst_u       slot [2];
  logic [4:0]  rj [2];
  logic [4:0]  rk [2];
  logic [4:0]  rd [2];
  logic        is_imm [2];
  logic        accept;
  logic        split;
  logic        issue1;
  logic        issue2;
  dec_lane_t   next1;
  dec_lane_t   next2;

  // youngest producer wins, r0 always comes from the file
  function automatic logic [31:0] resolve(input logic [4:0] addr, input logic [31:0] rf_val,
                                          input fwd_t e1, input fwd_t e2,
                                          input fwd_t w1, input fwd_t w2);
    logic [31:0] val;
    val = rf_val;
    if (addr != 5'd0) begin
      if (e2.valid && e2.dest == addr) val = e2.value;
      else if (e1.valid && e1.dest == addr) val = e1.value;
      else if (w2.valid && w2.dest == addr) val = w2.value;
      else if (w1.valid && w1.dest == addr) val = w1.value;
    end
    return val;
  endfunction

  function automatic dec_lane_t make_lane(input logic v, input inst_u inst,
                                          input logic [31:0] rj_val, input logic [31:0] rk_val,
                                          input logic [31:0] pc);
    dec_lane_t lane;
    lane.valid = v;
    lane.op    = inst.r_form.opcode;
    lane.src1  = rj_val;
    lane.pc    = pc;
    if (inst.r_form.opcode inside {OP_ADDI, OP_CSRWR}) begin
      lane.dest    = inst.i_form.rd;
      lane.csr_we  = inst.i_form.opcode == OP_CSRWR;
      lane.csr_num = lane.csr_we ? inst.i_form.field : 14'd0;
      lane.src2    = lane.csr_we ? 32'd0 :
                     {{20{inst.i_form.field[11]}}, inst.i_form.field[11:0]};
    end else begin
      lane.dest    = inst.r_form.rd;
      lane.csr_we  = 1'b0;
      lane.csr_num = 14'd0;
      lane.src2    = rk_val;
    end
    lane.gr_we = lane.dest != 5'd0;
    return lane;
  endfunction

  // a held lane 2 issues alone in slot 0
  always_comb begin
    slot[0] = held_valid ? held_inst : pair.inst1;
    slot[1] = pair.inst2;
    for (int i = 0; i < 2; i++) begin
      is_imm[i] = slot[i].r_form.opcode inside {OP_ADDI, OP_CSRWR};
      if (is_imm[i]) begin
        rj[i] = slot[i].i_form.rj;
        rd[i] = slot[i].i_form.rd;
        rk[i] = 5'd0;
      end else begin
        rj[i] = slot[i].r_form.rj;
        rd[i] = slot[i].r_form.rd;
        rk[i] = slot[i].r_form.rk;
      end
    end
  end

  assign rf_raddr = {rk[1], rj[1], rk[0], rj[0]};

  assign pair_ready = out_of_reset && wb_ready && !held_valid;
  assign accept     = pair_valid && pair_ready;

  // lane 2 depends on lane 1, or both touch the csr file
  assign split = (rd[0] != 5'd0 && (rj[1] == rd[0] || (!is_imm[1] && rk[1] == rd[0])))
              || (slot[0].r_form.opcode == OP_CSRWR && slot[1].r_form.opcode == OP_CSRWR);

  assign issue1 = held_valid || accept;
  assign issue2 = accept && !split;

  assign next1 = make_lane(issue1, slot[0],
                           resolve(rj[0], rf_rdata[0], ex_fwd1, ex_fwd2, wb_fwd1, wb_fwd2),
                           resolve(rk[0], rf_rdata[1], ex_fwd1, ex_fwd2, wb_fwd1, wb_fwd2),
                           pc_q);
  assign next2 = make_lane(issue2, slot[1],
                           resolve(rj[1], rf_rdata[2], ex_fwd1, ex_fwd2, wb_fwd1, wb_fwd2),
                           resolve(rk[1], rf_rdata[3], ex_fwd1, ex_fwd2, wb_fwd1, wb_fwd2),
                           pc_q + PC_STEP);

  always_ff @(posedge clk) begin
    if (reset) begin
      out_of_reset <= 1'b0;
      held_valid   <= 1'b0;
      pc_q         <= 32'd0;
      dec1.valid   <= 1'b0;
      dec2.valid   <= 1'b0;
    end else begin
      out_of_reset <= 1'b1;
      if (wb_ready) begin
        dec1 <= next1;
        dec2 <= next2;
        if (held_valid) held_valid <= 1'b0;
        else if (accept && split) held_valid <= 1'b1;
        if (issue2) pc_q <= pc_q + PC_STEP + PC_STEP;
        else if (issue1) pc_q <= pc_q + PC_STEP;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept && split) held_inst <= pair.inst2;
  end

endmodule

// File: rtl/dual_pkg.sv
package dual_pkg;

  // csr file depth, indexed by the low csr number bits
  localparam int CSR_COUNT = 16;
  localparam logic [31:0] PC_STEP = 32'd4;

  typedef enum logic [5:0] {
    OP_ADD   = 6'h01,
    OP_SUB   = 6'h02,
    OP_AND   = 6'h03,
    OP_OR    = 6'h04,
    OP_XOR   = 6'h05,
    OP_ADDI  = 6'h06,
    OP_CSRWR = 6'h07
  } op_e;

  // same word, two decodings picked by the opcode
  typedef union packed {
    struct packed {
      op_e         opcode;
      logic [10:0] unused;
      logic [4:0]  rk;
      logic [4:0]  rj;
      logic [4:0]  rd;
    } r_form;
    struct packed {
      op_e         opcode;
      logic [1:0]  unused;
      // addi imm in [11:0], csr number for csrwr
      logic [13:0] field;
      logic [4:0]  rj;
      logic [4:0]  rd;
    } i_form;
  } inst_u;

  // inst1 is the older of the pair
  typedef struct packed {
    inst_u inst1;
    inst_u inst2;
  } inst_pair_t;

  typedef struct packed {
    logic        valid;
    op_e         op;
    logic [4:0]  dest;
    logic        gr_we;
    logic        csr_we;
    logic [13:0] csr_num;
    logic [31:0] src1;
    logic [31:0] src2;
    logic [31:0] pc;
  } dec_lane_t;

  typedef struct packed {
    logic        valid;
    logic        gr_we;
    logic [4:0]  dest;
    logic [31:0] result;
    logic        csr_we;
    logic [13:0] csr_num;
    logic [31:0] csr_wdata;
    logic [31:0] pc;
  } wb_lane_t;

  typedef struct packed {
    logic        valid;
    logic [4:0]  dest;
    logic [31:0] value;
  } fwd_t;

  typedef struct packed {
    logic        we;
    logic [4:0]  addr;
    logic [31:0] data;
  } rf_wr_t;

  typedef struct packed {
    logic        we;
    logic [13:0] num;
    logic [31:0] data;
  } csr_wr_t;

  typedef struct packed {
    logic        valid;
    logic        we;
    logic [4:0]  dest;
    logic [31:0] data;
    logic [31:0] pc;
  } commit_t;

endpackage
